// ==== design/rv_decode_macros.svh ====
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// RV32I fixed widths.
`define RV_XLEN      32
`define RV_INSTR_W   32
`define RV_REG_IDX_W 5

// addi x0, x0, 0
`define RV_NOP_INSTR 32'h0000_0013

`endif

// ==== design/rv_isa_pkg.sv ====
`include "rv_decode_macros.svh"
`default_nettype none

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP     = 7'b0110011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    typedef struct packed {
        opcode_e                  opcode;
        logic [`RV_REG_IDX_W-1:0] rd;
        logic [`RV_REG_IDX_W-1:0] rs1;
        logic [`RV_REG_IDX_W-1:0] rs2;
        logic [2:0]               funct3;
        logic                     alt;      // Instruction bit 30.
        logic                     rs1_used;
        logic                     rs2_used;
        logic [`RV_XLEN-1:0]      imm_i;
        logic [`RV_XLEN-1:0]      imm_u;
        logic [`RV_XLEN-1:0]      imm_b;
        logic [`RV_XLEN-1:0]      imm_j;
        logic [4:0]               shamt;
    } instr_fields_t;

endpackage

`default_nettype wire

// ==== design/rv_pipe_pkg.sv ====
`include "rv_decode_macros.svh"
`default_nettype none

package rv_pipe_pkg;

    // Operation codes seen by execute.
    typedef enum logic [3:0] {
        EX_NOP  = 4'd0,
        EX_ADD  = 4'd1,
        EX_SUB  = 4'd2,
        EX_SLT  = 4'd3,
        EX_SLTU = 4'd4,
        EX_XOR  = 4'd5,
        EX_OR   = 4'd6,
        EX_AND  = 4'd7,
        EX_SLL  = 4'd8,
        EX_SRL  = 4'd9,
        EX_SRA  = 4'd10,
        EX_JMP  = 4'd11
    } exec_op_e;

    // Result travelling down the pipe towards writeback.
    typedef struct packed {
        logic                     en;
        logic                     ready;    // Value is valid this cycle.
        logic [`RV_REG_IDX_W-1:0] rd;
        logic [`RV_XLEN-1:0]      value;
    } wb_src_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]      pc;
        logic [`RV_XLEN-1:0]      op1;
        logic [`RV_XLEN-1:0]      op2;
        exec_op_e                 op;
        logic                     rd_en;
        logic [`RV_REG_IDX_W-1:0] rd;
    } issue_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] value;
        logic                stall;
    } operand_t;

endpackage

`default_nettype wire

// ==== design/rv_instr_fields.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"
`default_nettype none

module rv_instr_fields import rv_isa_pkg::*; (
    input  wire logic [`RV_INSTR_W-1:0] i_instr,
    input  wire logic                   i_squash,
    output instr_fields_t               o_fields
);

    logic [`RV_INSTR_W-1:0] instr;
    opcode_e                opcode;

    assign instr  = i_squash ? `RV_NOP_INSTR : i_instr; // Kill the jump shadow.
    assign opcode = opcode_e'(instr[6:0]);

    always_comb begin
        o_fields.opcode = opcode;
        o_fields.rd     = instr[11:7];
        o_fields.rs1    = instr[19:15];
        o_fields.rs2    = instr[24:20];
        o_fields.funct3 = instr[14:12];
        o_fields.alt    = instr[30];
        o_fields.shamt  = instr[24:20];

        o_fields.imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
        o_fields.imm_u = {instr[31:12], 12'b0};
        o_fields.imm_b = {{(`RV_XLEN-12){instr[31]}},
                          instr[7],
                          instr[30:25],
                          instr[11:8],
                          1'b0};
        o_fields.imm_j = {{(`RV_XLEN-20){instr[31]}},
                          instr[19:12],
                          instr[20],
                          instr[30:21],
                          1'b0};

        // Only real source reads may raise hazards.
        o_fields.rs1_used = 1'b0;
        o_fields.rs2_used = 1'b0;
        case (opcode)
            OPC_OP, OPC_BRANCH: begin
                o_fields.rs1_used = 1'b1;
                o_fields.rs2_used = 1'b1;
            end
            OPC_OP_IMM, OPC_JALR: begin
                o_fields.rs1_used = 1'b1;
            end
            default: begin
                o_fields.rs1_used = 1'b0; // LUI, AUIPC, JAL and unknown.
                o_fields.rs2_used = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv_operand_fwd.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"
`default_nettype none

module rv_operand_fwd import rv_pipe_pkg::*; (
    input  wire logic [`RV_REG_IDX_W-1:0] i_idx,
    input  wire logic                     i_used,
    input  wire logic [`RV_XLEN-1:0]      i_reg_val,
    input  wire issue_t                   i_issue,
    input  wire wb_src_t                  i_exec_wb,
    input  wire wb_src_t                  i_mem_wb,
    output operand_t                      o_operand
);

    logic issue_hit;
    logic exec_hit;
    logic mem_hit;

    // A producer targets this source; x0 is never a dependence.
    function automatic logic src_match(
        input logic                     en,
        input logic [`RV_REG_IDX_W-1:0] rd,
        input logic [`RV_REG_IDX_W-1:0] idx,
        input logic                     used
    );
        return en && used && (rd != '0) && (rd == idx);
    endfunction

    assign issue_hit = src_match(i_issue.rd_en, i_issue.rd, i_idx, i_used);
    assign exec_hit  = src_match(i_exec_wb.en, i_exec_wb.rd, i_idx, i_used);
    assign mem_hit   = src_match(i_mem_wb.en, i_mem_wb.rd, i_idx, i_used);

    always_comb begin
        // Result still in execute input, or not produced yet.
        o_operand.stall = issue_hit
                       || (exec_hit && !i_exec_wb.ready)
                       || (mem_hit && !i_mem_wb.ready);

        // Youngest producer wins.
        if (exec_hit) begin
            o_operand.value = i_exec_wb.value;
        end else if (mem_hit) begin
            o_operand.value = i_mem_wb.value;
        end else begin
            o_operand.value = i_reg_val;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_issue_reg.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"
`default_nettype none

module rv_issue_reg import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  wire logic                i_clk,
    input  wire logic                i_rst,
    input  wire instr_fields_t       i_fields,
    input  wire logic [`RV_XLEN-1:0] i_pc,
    input  wire operand_t            i_op1,
    input  wire operand_t            i_op2,
    output issue_t                   o_issue,
    output logic                     o_jmp_stall,
    output logic [`RV_XLEN-1:0]      o_jmp_pc,
    output logic                     o_hazard_stall
);

    issue_t              issue_q;
    issue_t              nxt_issue;
    logic                jmp_q;
    logic                nxt_jmp;
    logic [`RV_XLEN-1:0] jmp_pc_q;
    logic [`RV_XLEN-1:0] nxt_jmp_pc;
    logic                taken;
    logic                is_shift;
    alu_f3_e             alu_f3;

    function automatic exec_op_e alu_op(
        input alu_f3_e f3,
        input logic    alt,
        input logic    reg_op
    );
        case (f3)
            F3_ADD_SUB: alu_op = (reg_op && alt) ? EX_SUB : EX_ADD; // No SUBI.
            F3_SLL:     alu_op = EX_SLL;
            F3_SLT:     alu_op = EX_SLT;
            F3_SLTU:    alu_op = EX_SLTU;
            F3_XOR:     alu_op = EX_XOR;
            F3_SRL_SRA: alu_op = alt ? EX_SRA : EX_SRL;
            F3_OR:      alu_op = EX_OR;
            F3_AND:     alu_op = EX_AND;
            default:    alu_op = EX_NOP;
        endcase
    endfunction

    assign o_hazard_stall = i_op1.stall || i_op2.stall;
    assign alu_f3         = alu_f3_e'(i_fields.funct3);
    assign is_shift       = (alu_f3 == F3_SLL) || (alu_f3 == F3_SRL_SRA);

    always_comb begin
        case (branch_f3_e'(i_fields.funct3))
            F3_BEQ:  taken = i_op1.value == i_op2.value;
            F3_BNE:  taken = i_op1.value != i_op2.value;
            F3_BLT:  taken = $signed(i_op1.value) < $signed(i_op2.value);
            F3_BGE:  taken = $signed(i_op1.value) >= $signed(i_op2.value);
            F3_BLTU: taken = i_op1.value < i_op2.value;
            F3_BGEU: taken = i_op1.value >= i_op2.value;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        // Bubble unless a valid instruction decodes below.
        nxt_issue       = '0;
        nxt_issue.pc    = i_pc;
        nxt_issue.op    = EX_NOP;
        nxt_jmp         = 1'b0;
        nxt_jmp_pc      = jmp_pc_q;

        if (!o_hazard_stall && !jmp_q) begin
            case (i_fields.opcode)
                OPC_OP_IMM: begin
                    nxt_issue.op    = alu_op(alu_f3, i_fields.alt, 1'b0);
                    nxt_issue.op1   = i_op1.value;
                    nxt_issue.op2   = is_shift ? {{(`RV_XLEN-5){1'b0}}, i_fields.shamt}
                                               : i_fields.imm_i;
                    nxt_issue.rd_en = 1'b1;
                    nxt_issue.rd    = i_fields.rd;
                end
                OPC_OP: begin
                    nxt_issue.op    = alu_op(alu_f3, i_fields.alt, 1'b1);
                    nxt_issue.op1   = i_op1.value;
                    nxt_issue.op2   = i_op2.value;
                    nxt_issue.rd_en = 1'b1;
                    nxt_issue.rd    = i_fields.rd;
                end
                OPC_LUI: begin
                    nxt_issue.op    = EX_ADD; // 0 + U immediate.
                    nxt_issue.op2   = i_fields.imm_u;
                    nxt_issue.rd_en = 1'b1;
                    nxt_issue.rd    = i_fields.rd;
                end
                OPC_AUIPC: begin
                    nxt_issue.op    = EX_ADD;
                    nxt_issue.op1   = i_pc;
                    nxt_issue.op2   = i_fields.imm_u;
                    nxt_issue.rd_en = 1'b1;
                    nxt_issue.rd    = i_fields.rd;
                end
                OPC_JAL, OPC_JALR: begin
                    nxt_issue.op    = EX_JMP; // Execute forms pc + 4 as link.
                    nxt_issue.op1   = i_pc;
                    nxt_issue.op2   = `RV_XLEN'd4;
                    nxt_issue.rd_en = 1'b1;
                    nxt_issue.rd    = i_fields.rd;
                    nxt_jmp         = 1'b1;
                    nxt_jmp_pc      = (i_fields.opcode == OPC_JAL)
                                    ? i_pc + i_fields.imm_j
                                    : i_op1.value + i_fields.imm_i;
                end
                OPC_BRANCH: begin
                    nxt_jmp         = taken;
                    nxt_jmp_pc      = i_pc + i_fields.imm_b;
                end
                default: begin
                    nxt_jmp         = 1'b0; // Unknown opcode issues a bubble.
                end
            endcase
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            issue_q  <= '0;
            jmp_q    <= 1'b0;
            jmp_pc_q <= '0;
        end else begin
            issue_q  <= nxt_issue;
            jmp_q    <= nxt_jmp;
            jmp_pc_q <= nxt_jmp_pc;
        end
    end

    assign o_issue     = issue_q;
    assign o_jmp_stall = jmp_q;
    assign o_jmp_pc    = jmp_pc_q;

endmodule

`default_nettype wire

// ==== design/rv_decode_stage.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"
`default_nettype none

module rv_decode_stage import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  wire logic                     i_clk,
    input  wire logic                     i_rst,
    input  wire logic [`RV_INSTR_W-1:0]   i_if_instr,
    input  wire logic [`RV_XLEN-1:0]      i_if_pc,
    output logic                          o_if_jmp_stall,
    output logic [`RV_XLEN-1:0]           o_if_jmp_pc,
    output logic                          o_if_hazard_stall,
    output logic [`RV_REG_IDX_W-1:0]      o_reg_r1,
    output logic [`RV_REG_IDX_W-1:0]      o_reg_r2,
    input  wire logic [`RV_XLEN-1:0]      i_reg_r1_reg,
    input  wire logic [`RV_XLEN-1:0]      i_reg_r2_reg,
    input  wire wb_src_t                  i_exec_wb,
    input  wire wb_src_t                  i_mem_wb,
    output issue_t                        o_exec
);

    instr_fields_t                   fields;
    issue_t                          issue;
    logic                            jmp_stall;
    logic [1:0][`RV_REG_IDX_W-1:0]   src_idx;
    logic [1:0]                      src_used;
    logic [1:0][`RV_XLEN-1:0]        src_reg;
    operand_t [1:0]                  src_op;

    rv_instr_fields rv_instr_fields_i (
        .i_instr  (i_if_instr),
        .i_squash (jmp_stall),
        .o_fields (fields)
    );

    assign src_idx  = {fields.rs2, fields.rs1};
    assign src_used = {fields.rs2_used, fields.rs1_used};
    assign src_reg  = {i_reg_r2_reg, i_reg_r1_reg};

    genvar g;
    for (g = 0; g < 2; g++) begin : g_src
        rv_operand_fwd rv_operand_fwd_i (
            .i_idx     (src_idx[g]),
            .i_used    (src_used[g]),
            .i_reg_val (src_reg[g]),
            .i_issue   (issue),
            .i_exec_wb (i_exec_wb),
            .i_mem_wb  (i_mem_wb),
            .o_operand (src_op[g])
        );
    end

    rv_issue_reg rv_issue_reg_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_fields       (fields),
        .i_pc           (i_if_pc),
        .i_op1          (src_op[0]),
        .i_op2          (src_op[1]),
        .o_issue        (issue),
        .o_jmp_stall    (jmp_stall),
        .o_jmp_pc       (o_if_jmp_pc),
        .o_hazard_stall (o_if_hazard_stall)
    );

    assign o_reg_r1       = fields.rs1; // Register file answers this cycle.
    assign o_reg_r2       = fields.rs2;
    assign o_if_jmp_stall = jmp_stall;
    assign o_exec         = issue;

endmodule

`default_nettype wire

// ==== sim/tb_rv_decode_stage.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"
`default_nettype none

module tb_rv_decode_stage import rv_isa_pkg::*, rv_pipe_pkg::*; ();

    localparam int TIMEOUT = 20;

    logic                     i_clk;
    logic                     i_rst;
    logic [`RV_INSTR_W-1:0]   if_instr;
    logic [`RV_XLEN-1:0]      if_pc;
    logic [`RV_XLEN-1:0]      next_pc;
    logic [`RV_XLEN-1:0]      reg_r1_val;
    logic [`RV_XLEN-1:0]      reg_r2_val;
    wb_src_t                  exec_wb;
    wb_src_t                  mem_wb;
    logic                     o_if_jmp_stall;
    logic [`RV_XLEN-1:0]      o_if_jmp_pc;
    logic                     o_if_hazard_stall;
    logic [`RV_REG_IDX_W-1:0] o_reg_r1;
    logic [`RV_REG_IDX_W-1:0] o_reg_r2;
    issue_t                   o_exec;

    integer                   seed;
    string                    test_name;

    // Reference model state.
    issue_t                   exp_issue;
    logic                     exp_jmp;
    logic [`RV_XLEN-1:0]      exp_jmp_pc;
    issue_t                   pred_issue;
    logic                     pred_stall;
    logic                     pred_jmp;
    logic [`RV_XLEN-1:0]      pred_jpc;
    logic [`RV_REG_IDX_W-1:0] pred_idx1;
    logic [`RV_REG_IDX_W-1:0] pred_idx2;
    issue_t                   chk_issue;
    logic                     chk_stall;
    logic                     chk_jmp;
    logic [`RV_XLEN-1:0]      chk_jpc;
    logic [`RV_REG_IDX_W-1:0] chk_idx1;
    logic [`RV_REG_IDX_W-1:0] chk_idx2;

    rv_decode_stage rv_decode_stage_i (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_if_instr        (if_instr),
        .i_if_pc           (if_pc),
        .o_if_jmp_stall    (o_if_jmp_stall),
        .o_if_jmp_pc       (o_if_jmp_pc),
        .o_if_hazard_stall (o_if_hazard_stall),
        .o_reg_r1          (o_reg_r1),
        .o_reg_r2          (o_reg_r2),
        .i_reg_r1_reg      (reg_r1_val),
        .i_reg_r2_reg      (reg_r2_val),
        .i_exec_wb         (exec_wb),
        .i_mem_wb          (mem_wb),
        .o_exec            (o_exec)
    );

    initial i_clk = 1'b0;
    always #50 i_clk = ~i_clk;

    // Register file model. Odd registers hold negative values and x0 reads zero.
    function automatic logic [31:0] rf_value(input logic [4:0] idx);
        if (idx == 5'd0) return 32'd0;
        return {idx[0], idx[4:1], 3'b101, idx ^ 5'h15, 3'b010, ~idx, 3'b110, idx, 3'b001};
    endfunction

    assign reg_r1_val = rf_value(o_reg_r1);
    assign reg_r2_val = rf_value(o_reg_r2);

    function automatic logic producer_hit(input logic en, input logic [4:0] rd,
                                          input logic [4:0] idx, input logic used);
        return en && used && (idx != 5'd0) && (rd == idx);
    endfunction

    function automatic logic src_stall(input logic [4:0] idx, input logic used);
        return producer_hit(exp_issue.rd_en, exp_issue.rd, idx, used)
            || (producer_hit(exec_wb.en, exec_wb.rd, idx, used) && !exec_wb.ready)
            || (producer_hit(mem_wb.en, mem_wb.rd, idx, used) && !mem_wb.ready);
    endfunction

    function automatic logic [31:0] fwd_value(input logic [4:0] idx, input logic used);
        if (producer_hit(exec_wb.en, exec_wb.rd, idx, used)) return exec_wb.value;
        if (producer_hit(mem_wb.en, mem_wb.rd, idx, used)) return mem_wb.value;
        return rf_value(idx);
    endfunction

    function automatic exec_op_e alu_expect(input logic [2:0] f3, input logic alt,
                                            input logic is_op);
        case (f3)
            3'b000:  return (is_op && alt) ? EX_SUB : EX_ADD;
            3'b001:  return EX_SLL;
            3'b010:  return EX_SLT;
            3'b011:  return EX_SLTU;
            3'b100:  return EX_XOR;
            3'b101:  return alt ? EX_SRA : EX_SRL;
            3'b110:  return EX_OR;
            default: return EX_AND;
        endcase
    endfunction

    // Next issue record, stall and jump from the current inputs and model state.
    task automatic predict(output issue_t nxt, output logic stall, output logic jmp,
                           output logic [31:0] jpc, output logic [4:0] idx1,
                           output logic [4:0] idx2);
        logic [31:0] ins;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        u1;
        logic        u2;
        logic        is_op;
        logic        taken;
        ins   = exp_jmp ? `RV_NOP_INSTR : if_instr;
        opc   = ins[6:0];
        f3    = ins[14:12];
        idx1  = ins[19:15];
        idx2  = ins[24:20];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'b0};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        is_op = (opc == OPC_OP);
        u1    = is_op || opc == OPC_BRANCH || opc == OPC_OP_IMM || opc == OPC_JALR;
        u2    = is_op || opc == OPC_BRANCH;
        v1    = fwd_value(idx1, u1);
        v2    = fwd_value(idx2, u2);
        stall = src_stall(idx1, u1) || src_stall(idx2, u2);
        nxt    = '0;
        nxt.pc = if_pc;
        nxt.op = EX_NOP;
        jmp    = 1'b0;
        jpc    = exp_jmp_pc;
        if (!stall && !exp_jmp) begin
            case (opc)
                OPC_OP_IMM, OPC_OP: begin
                    nxt.op  = alu_expect(f3, ins[30], is_op);
                    nxt.op1 = v1;
                    if (is_op) nxt.op2 = v2;
                    else if (f3 == 3'b001 || f3 == 3'b101) nxt.op2 = {27'b0, ins[24:20]};
                    else nxt.op2 = imm_i;
                    nxt.rd_en = 1'b1;
                    nxt.rd    = ins[11:7];
                end
                OPC_LUI, OPC_AUIPC: begin
                    nxt.op    = EX_ADD;
                    nxt.op1   = (opc == OPC_AUIPC) ? if_pc : 32'd0;
                    nxt.op2   = imm_u;
                    nxt.rd_en = 1'b1;
                    nxt.rd    = ins[11:7];
                end
                OPC_JAL, OPC_JALR: begin
                    nxt.op    = EX_JMP;
                    nxt.op1   = if_pc;
                    nxt.op2   = 32'd4;
                    nxt.rd_en = 1'b1;
                    nxt.rd    = ins[11:7];
                    jmp       = 1'b1;
                    jpc       = (opc == OPC_JAL) ? if_pc + imm_j : v1 + imm_i;
                end
                OPC_BRANCH: begin
                    case (f3)
                        3'b000:  taken = v1 == v2;
                        3'b001:  taken = v1 != v2;
                        3'b100:  taken = $signed(v1) < $signed(v2);
                        3'b101:  taken = $signed(v1) >= $signed(v2);
                        3'b110:  taken = v1 < v2;
                        3'b111:  taken = v1 >= v2;
                        default: taken = 1'b0;
                    endcase
                    jmp = taken;
                    jpc = if_pc + imm_b;
                end
                default: ;
            endcase
        end
    endtask

    always @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            exp_issue  <= '0;
            exp_jmp    <= 1'b0;
            exp_jmp_pc <= '0;
        end else begin
            predict(pred_issue, pred_stall, pred_jmp, pred_jpc, pred_idx1, pred_idx2);
            exp_issue  <= pred_issue;
            exp_jmp    <= pred_jmp;
            exp_jmp_pc <= pred_jpc;
        end
    end

    task automatic check_field(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout in %s: %s", test_name, what);
        $display("Errors found");
        $fatal(1);
    endtask

    // Outputs are settled half a cycle after the edge.
    always @(negedge i_clk) begin
        if (!i_rst) begin
            predict(chk_issue, chk_stall, chk_jmp, chk_jpc, chk_idx1, chk_idx2);
            check_field("o_exec", exp_issue, o_exec);
            check_field("o_if_jmp_stall", exp_jmp, o_if_jmp_stall);
            if (exp_jmp) check_field("o_if_jmp_pc", exp_jmp_pc, o_if_jmp_pc);
            check_field("o_if_hazard_stall", chk_stall, o_if_hazard_stall);
            check_field("o_reg_r1", chk_idx1, o_reg_r1);
            check_field("o_reg_r2", chk_idx2, o_reg_r2);
        end
    end

    function automatic wb_src_t mk_wb(input logic en, input logic ready,
                                      input logic [4:0] rd, input logic [31:0] value);
        wb_src_t w;
        w.en    = en;
        w.ready = ready;
        w.rd    = rd;
        w.value = value;
        return w;
    endfunction

    function automatic logic [31:0] rand_alu(input logic [4:0] rs_base,
                                             input logic [4:0] rs_mask,
                                             input logic [4:0] rd_base,
                                             input logic [4:0] rd_mask);
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        r   = $random(seed);
        r2  = $random(seed);
        rs1 = rs_base + (r[4:0] & rs_mask);
        rs2 = rs_base + (r[9:5] & rs_mask);
        rd  = rd_base + (r[14:10] & rd_mask);
        f3  = r[17:15];
        f7  = (r[18] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
        case (r[20:19])
            2'd0: return {f7, rs2, rs1, f3, rd, OPC_OP};
            2'd1: begin
                if (f3 == 3'b001 || f3 == 3'b101) imm = {f7, r2[4:0]}; // Shift amount.
                else imm = r2[11:0];
                return {imm, rs1, f3, rd, OPC_OP_IMM};
            end
            2'd2:    return {r2[19:0], rd, OPC_LUI};
            default: return {r2[19:0], rd, OPC_AUIPC};
        endcase
    endfunction

    function automatic logic [31:0] rand_ctrl();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        r   = $random(seed);
        r2  = $random(seed);
        rs1 = 5'd1 + r[8:6];
        rs2 = r[9] ? rs1 : 5'd1 + r[12:10];
        rd  = 5'd16 + r[16:13];
        f3  = (r[5:3] == 3'd2 || r[5:3] == 3'd3) ? r[5:3] + 3'd2 : r[5:3];
        case (r[2:0])
            3'd0: return {r2[20], r2[10:1], r2[11], r2[19:12], rd, OPC_JAL};
            3'd1: return {r2[11:0], rs1, 3'b000, rd, OPC_JALR};
            default: return {r2[12], r2[10:5], rs2, rs1, f3, r2[4:1], r2[11], OPC_BRANCH};
        endcase
    endfunction

    // Presents one instruction and holds it while decode stalls.
    task automatic send(input logic [31:0] instr, input wb_src_t ex, input wb_src_t mem);
        int n;
        @(posedge i_clk);
        #1;
        if_instr = instr;
        if_pc    = next_pc;
        exec_wb  = ex;
        mem_wb   = mem;
        #1;
        n = 0;
        while (o_if_hazard_stall && n < TIMEOUT) begin
            @(posedge i_clk);
            #1;
            exec_wb.ready = 1'b1; // Later stages finish their results.
            mem_wb.ready  = 1'b1;
            #1;
            n++;
        end
        if (n == TIMEOUT) fail_timeout("hazard stall never cleared");
        next_pc = next_pc + 32'd4;
    endtask

    task automatic wait_jmp();
        int n;
        n = 0;
        @(posedge i_clk);
        #1;
        while (!o_if_jmp_stall && n < TIMEOUT) begin
            @(posedge i_clk);
            #1;
            n++;
        end
        if (n == TIMEOUT) fail_timeout("jump stall never rose");
    endtask

    initial begin
        wb_src_t ex;
        wb_src_t mem;
        logic [31:0] ins;
        seed      = 32'hf703;
        test_name = "reset";
        i_rst     = 1'b1;
        if_instr  = `RV_NOP_INSTR;
        if_pc     = '0;
        next_pc   = 32'h0000_1000;
        exec_wb   = '0;
        mem_wb    = '0;
        repeat (16) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        @(negedge i_clk);
        check_field("rd_en", 1'b0, o_exec.rd_en);
        check_field("op", EX_NOP, o_exec.op);
        check_field("jmp_stall", 1'b0, o_if_jmp_stall);

        test_name = "alu_independent";
        repeat (40) send(rand_alu(5'd1, 5'd7, 5'd16, 5'd15), '0, '0);

        test_name = "hazard_stall";
        send({12'h005, 5'd1, 3'b000, 5'd5, OPC_OP_IMM}, '0, '0);
        send({7'b0, 5'd1, 5'd5, 3'b000, 5'd6, OPC_OP}, '0, '0);
        send({7'b0, 5'd2, 5'd9, 3'b000, 5'd7, OPC_OP},
             mk_wb(1'b1, 1'b0, 5'd9, 32'h1111_0009), mk_wb(1'b1, 1'b1, 5'd2, 32'h2222_0002));
        send({7'b0, 5'd3, 5'd10, 3'b000, 5'd11, OPC_OP},
             mk_wb(1'b1, 1'b1, 5'd10, 32'h1111_000a), mk_wb(1'b1, 1'b0, 5'd3, 32'h2222_0003));
        send({12'h001, 5'd0, 3'b000, 5'd0, OPC_OP_IMM}, '0, '0);
        send({7'b0, 5'd0, 5'd0, 3'b000, 5'd8, OPC_OP},
             mk_wb(1'b1, 1'b0, 5'd0, 32'h3), mk_wb(1'b1, 1'b0, 5'd0, 32'h4));

        test_name = "forwarding";
        repeat (40) begin
            ins = rand_alu(5'd0, 5'd3, 5'd8, 5'd7);
            ex  = mk_wb(1'b1, 1'b1, 5'($unsigned($random(seed)) % 4), $random(seed));
            mem = mk_wb(1'b1, 1'b1, 5'($unsigned($random(seed)) % 4), $random(seed));
            if ($random(seed) & 1) mem.rd = ex.rd;
            send(ins, ex, mem);
        end

        test_name = "jumps_branches";
        repeat (30) begin
            ins = rand_ctrl();
            ex  = mk_wb(1'($random(seed)), 1'b1,
                        5'd1 + 5'($unsigned($random(seed)) % 8), $random(seed));
            send(ins, ex, '0);
            if (ins[6:0] == OPC_JAL || ins[6:0] == OPC_JALR) wait_jmp();
            send(rand_alu(5'd1, 5'd7, 5'd16, 5'd15), '0, '0);
        end

        repeat (4) @(posedge i_clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_instr_fields.sv
design/rv_operand_fwd.sv
design/rv_issue_reg.sv
design/rv_decode_stage.sv
sim/tb_rv_decode_stage.sv

// ==== Bender.yml ====
package:
  name: rv_decode_stage

sources:
  - include_dirs:
      - design
    files:
      - design/rv_isa_pkg.sv
      - design/rv_pipe_pkg.sv
      - design/rv_instr_fields.sv
      - design/rv_operand_fwd.sv
      - design/rv_issue_reg.sv
      - design/rv_decode_stage.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_rv_decode_stage.sv
